// ==== tb.f ====
+incdir+common
common/rv_isa_pkg.sv
common/rv_mem_pkg.sv
mem_stage/mem_dcache_port.sv
mem_stage/mem_clint.sv
mem_stage/mem_stage.sv
rtl/dcache_ram.sv
rtl/mem_subsys_top.sv
verif/mem_subsys_properties.sv
verif/mem_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module mem_subsys_tb -o mem_subsys_sim
./obj_dir/mem_subsys_sim

// ==== verif/mem_subsys_tb.sv ====
// random stimulus from a fixed seed; loads only touch words first written by a full store
// RAM addresses stay inside the RAM so that no two addresses alias
`timescale 1ns/1ps
`include "rv_mem_defs.svh"

module mem_subsys_tb;

  localparam int N_INIT = 16;
  localparam int N_ST = 40;
  localparam int N_LD = 60;
  localparam int N_PT = 20;
  localparam int N_CLINT = 6;
  localparam int N_BP = 30;
  localparam int N_TXN = N_INIT + N_ST + N_LD + N_PT + N_CLINT + N_BP;
  localparam int IDX_HI = $clog2(`RAM_WORDS) + 2;

  typedef struct packed {
    rv_isa_pkg::mem_op_e op;
    logic [63:0]         pc;
    logic [31:0]         inst;
    logic [4:0]          rd;
    logic                rd_wen;
    logic [63:0]         data;
    logic                skip;
    logic                is_mtime;
  } wb_exp_t;

  logic                clk;
  logic                rst;
  logic                i_ex_valid;
  logic                o_ex_ready;
  logic [63:0]         i_ex_pc;
  logic [31:0]         i_ex_inst;
  logic [4:0]          i_ex_rd;
  logic                i_ex_rd_wen;
  logic [63:0]         i_ex_rd_wdata;
  rv_isa_pkg::mem_op_e i_ex_op;
  logic [63:0]         i_ex_base;
  logic [63:0]         i_ex_offset;
  logic [63:0]         i_ex_sdata;
  logic                o_wb_valid;
  logic                i_wb_ack;
  logic [63:0]         o_wb_pc;
  logic [31:0]         o_wb_inst;
  logic [4:0]          o_wb_rd;
  logic                o_wb_rd_wen;
  logic [63:0]         o_wb_rd_wdata;
  logic                o_wb_skipcmt;
  logic                o_clint_irq;

  // reference model
  logic [63:0] ref_mem [`RAM_WORDS];
  logic [63:0] mtimecmp_model;
  logic [63:0] last_mtime;
  int          used [N_INIT];
  wb_exp_t     exp_q [$];
  bit          bp_en;

  rv_isa_pkg::mem_op_e load_ops [7] = '{rv_isa_pkg::LB, rv_isa_pkg::LBU, rv_isa_pkg::LH,
    rv_isa_pkg::LHU, rv_isa_pkg::LW, rv_isa_pkg::LWU, rv_isa_pkg::LD};
  rv_isa_pkg::mem_op_e store_ops [4] = '{rv_isa_pkg::SB, rv_isa_pkg::SH, rv_isa_pkg::SW,
    rv_isa_pkg::SD};

  mem_subsys_top i_mem_subsys_top (.*);

  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "run aborted");
  endtask

  task automatic value_mismatch(input string msg);
    abort_run($sformatf("Fail %0t: %s", $time, msg));
  endtask

  function automatic int op_bytes(input rv_isa_pkg::mem_op_e op);
    case (op)
      rv_isa_pkg::LB, rv_isa_pkg::LBU, rv_isa_pkg::SB: return 1;
      rv_isa_pkg::LH, rv_isa_pkg::LHU, rv_isa_pkg::SH: return 2;
      rv_isa_pkg::LW, rv_isa_pkg::LWU, rv_isa_pkg::SW: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic bit reads_mem(input rv_isa_pkg::mem_op_e op);
    return op inside {rv_isa_pkg::LB, rv_isa_pkg::LBU, rv_isa_pkg::LH, rv_isa_pkg::LHU,
                      rv_isa_pkg::LW, rv_isa_pkg::LWU, rv_isa_pkg::LD};
  endfunction

  function automatic bit writes_mem(input rv_isa_pkg::mem_op_e op);
    return op inside {rv_isa_pkg::SB, rv_isa_pkg::SH, rv_isa_pkg::SW, rv_isa_pkg::SD};
  endfunction

  function automatic rv_mem_pkg::chan_e target_chan(input rv_isa_pkg::mem_op_e op,
                                                    input logic [63:0] addr);
    if (!(reads_mem(op) || writes_mem(op))) return rv_mem_pkg::NONE;
    if ((addr[31:0] & `WIN_MASK) == `MEM_BASE) return rv_mem_pkg::MEM;
    if ((addr[31:0] & `WIN_MASK) == `MMIO_BASE) return rv_mem_pkg::MMIO;
    return rv_mem_pkg::NONE;
  endfunction

  // expected write-back data, taken before a store updates the model
  function automatic logic [63:0] exp_result(input rv_isa_pkg::mem_op_e op,
                                             input logic [63:0] addr, input logic [63:0] fwd);
    rv_mem_pkg::chan_e ch;
    logic [63:0]       sh;
    ch = target_chan(op, addr);
    if (!reads_mem(op) || ch == rv_mem_pkg::NONE) return fwd;
    if (ch == rv_mem_pkg::MMIO) return (addr[31:0] == `CLINT_MTIMECMP) ? mtimecmp_model : '0;
    sh = ref_mem[addr[IDX_HI:3]] >> {addr[2:0], 3'b000};
    case (op)
      rv_isa_pkg::LB:  return {{56{sh[7]}}, sh[7:0]};
      rv_isa_pkg::LBU: return {56'd0, sh[7:0]};
      rv_isa_pkg::LH:  return {{48{sh[15]}}, sh[15:0]};
      rv_isa_pkg::LHU: return {48'd0, sh[15:0]};
      rv_isa_pkg::LW:  return {{32{sh[31]}}, sh[31:0]};
      rv_isa_pkg::LWU: return {32'd0, sh[31:0]};
      default: return sh;
    endcase
  endfunction

  task automatic store_model(input rv_isa_pkg::mem_op_e op, input logic [63:0] addr,
                             input logic [63:0] sdata);
    int n;
    n = op_bytes(op);
    if (target_chan(op, addr) == rv_mem_pkg::MEM) begin
      for (int i = 0; i < n; i++) begin
        ref_mem[addr[IDX_HI:3]][(int'(addr[2:0]) + i) * 8 +: 8] = sdata[i * 8 +: 8];
      end
    end else if (target_chan(op, addr) == rv_mem_pkg::MMIO &&
                 addr[31:0] == `CLINT_MTIMECMP) begin
      mtimecmp_model = sdata & ((64'd1 << (n * 8)) - 64'd1);
    end
  endtask

  // one instruction; inject holds valid with other fields while the stage is busy
  task automatic issue(input rv_isa_pkg::mem_op_e op, input logic [63:0] addr,
                       input logic [63:0] sdata, input bit mtime_rd, input bit inject);
    wb_exp_t     e;
    logic [63:0] off;
    logic [63:0] fwd;
    off = 64'($urandom % 256) - 64'd128;
    fwd = {$urandom, $urandom};
    @(negedge clk);
    while (!o_ex_ready) @(negedge clk);
    i_ex_op = op;
    i_ex_base = addr - off;
    i_ex_offset = off;
    i_ex_sdata = sdata;
    i_ex_rd_wdata = fwd;
    i_ex_pc = {$urandom, $urandom};
    i_ex_inst = $urandom;
    i_ex_rd = 5'($urandom);
    i_ex_rd_wen = 1'($urandom);
    e = '{op: op, pc: i_ex_pc, inst: i_ex_inst, rd: i_ex_rd, rd_wen: i_ex_rd_wen,
          data: exp_result(op, addr, fwd),
          skip: (target_chan(op, addr) == rv_mem_pkg::MMIO), is_mtime: mtime_rd};
    if (writes_mem(op)) store_model(op, addr, sdata);
    exp_q.push_back(e);
    i_ex_valid = 1'b1;
    @(negedge clk);
    if (inject) begin
      assert (!o_ex_ready) else abort_run("ready still high right after accept");
      i_ex_pc = ~i_ex_pc;
      i_ex_rd_wdata = ~fwd;
      @(negedge clk);
    end
    i_ex_valid = 1'b0;
  endtask

  task automatic rand_mem(input bit load, input bit inject);
    rv_isa_pkg::mem_op_e op;
    logic [2:0]          off;
    int                  k;
    op = load ? load_ops[$urandom % 7] : store_ops[$urandom % 4];
    off = 3'($urandom % 8) & ~3'(op_bytes(op) - 1);
    k = $urandom % N_INIT;
    issue(op, 64'(`MEM_BASE) + 64'(used[k]) * 8 + 64'(off), {$urandom, $urandom}, 1'b0,
          inject);
  endtask

  // non-memory op, or an access outside both windows
  task automatic passthrough(input bit inject);
    logic [63:0] addr;
    addr = {32'd0, 32'h1000_0000 | ($urandom & 32'h00FF_FFF8)};
    if ($urandom % 2 == 0) begin
      issue(rv_isa_pkg::NONE, {$urandom, $urandom}, {$urandom, $urandom}, 1'b0, inject);
    end else begin
      issue(($urandom % 2 == 0) ? rv_isa_pkg::LD : rv_isa_pkg::SW, addr,
            {$urandom, $urandom}, 1'b0, inject);
    end
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (exp_q.size() != 0 || !o_ex_ready) @(negedge clk);
  endtask

  task automatic check_wb();
    wb_exp_t e;
    assert (exp_q.size() != 0) else abort_run("write-back seen with no instruction in flight");
    e = exp_q.pop_front();
    assert (o_wb_pc == e.pc && o_wb_inst == e.inst && o_wb_rd == e.rd &&
            o_wb_rd_wen == e.rd_wen)
      else value_mismatch($sformatf("pc %h inst %h rd %0d wen %b, expected %h %h %0d %b",
        o_wb_pc, o_wb_inst, o_wb_rd, o_wb_rd_wen, e.pc, e.inst, e.rd, e.rd_wen));
    assert (o_wb_skipcmt == e.skip)
      else value_mismatch($sformatf("skipcmt %b, expected %b for %s", o_wb_skipcmt, e.skip,
        e.op.name()));
    if (e.is_mtime) begin
      assert (o_wb_rd_wdata > last_mtime)
        else value_mismatch($sformatf("mtime %0d not above previous %0d", o_wb_rd_wdata,
          last_mtime));
      last_mtime = o_wb_rd_wdata;
    end else begin
      assert (o_wb_rd_wdata == e.data)
        else value_mismatch($sformatf("rd_wdata %h, expected %h for %s", o_wb_rd_wdata,
          e.data, e.op.name()));
    end
  endtask

  // compare on each write-back handshake
  always @(posedge clk) begin
    if (!rst && o_wb_valid && i_wb_ack) check_wb();
  end

  // random ack holds when back-pressure is on
  always @(negedge clk) begin
    i_wb_ack = bp_en ? ($urandom % 4 == 0) : 1'b1;
  end

  initial begin
    repeat (N_TXN * 20 + 100) @(posedge clk);
    abort_run($sformatf("timeout, %0d transactions did not finish in time", N_TXN));
  end

  initial begin
    void'($urandom(32'h8102));
    clk = 1'b0;
    rst = 1'b1;
    bp_en = 1'b0;
    i_wb_ack = 1'b0;
    i_ex_valid = 1'b0;
    i_ex_pc = '0;
    i_ex_inst = '0;
    i_ex_rd = '0;
    i_ex_rd_wen = 1'b0;
    i_ex_rd_wdata = '0;
    i_ex_op = rv_isa_pkg::NONE;
    i_ex_base = '0;
    i_ex_offset = '0;
    i_ex_sdata = '0;
    mtimecmp_model = '1;
    last_mtime = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    assert (o_ex_ready && !o_wb_valid && !o_clint_irq)
      else abort_run("outputs not idle after reset");
    for (int j = 0; j < N_INIT; j++) begin
      used[j] = j * 16 + int'($urandom % 16);
      issue(rv_isa_pkg::SD, 64'(`MEM_BASE) + 64'(used[j]) * 8, {$urandom, $urandom}, 1'b0,
            1'b0);
    end
    for (int j = 0; j < N_ST; j++) rand_mem(1'b0, 1'b0);
    for (int j = 0; j < N_LD; j++) rand_mem(1'b1, 1'b0);
    for (int j = 0; j < N_PT; j++) passthrough(1'b0);
    // CLINT
    issue(rv_isa_pkg::SD, 64'(`CLINT_MTIMECMP), {$urandom, $urandom}, 1'b0, 1'b0);
    issue(rv_isa_pkg::LD, 64'(`CLINT_MTIMECMP), '0, 1'b0, 1'b0);
    issue(rv_isa_pkg::LD, 64'(`CLINT_MTIME), '0, 1'b1, 1'b0);
    issue(rv_isa_pkg::LD, 64'(`CLINT_MTIME), '0, 1'b1, 1'b0);
    issue(rv_isa_pkg::SD, 64'(`CLINT_MTIMECMP), '0, 1'b0, 1'b0);
    wait_idle();
    assert (o_clint_irq) else abort_run("timer interrupt not raised with mtimecmp at 0");
    issue(rv_isa_pkg::SD, 64'(`CLINT_MTIMECMP), '1, 1'b0, 1'b0);
    wait_idle();
    assert (!o_clint_irq) else abort_run("timer interrupt still high with mtimecmp all ones");
    bp_en = 1'b1;
    for (int j = 0; j < N_BP; j++) begin
      case ($urandom % 3)
        0: rand_mem(1'b0, 1'b1);
        1: rand_mem(1'b1, 1'b1);
        default: passthrough(1'b1);
      endcase
    end
    wait_idle();
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== verif/mem_subsys_properties.sv ====
// handshake checks bound into every mem_stage instance
`timescale 1ns/1ps
`include "rv_mem_defs.svh"

module mem_subsys_properties (
  input logic             clk,
  input logic             rst,
  input logic             i_ex_ready,
  input logic             i_wb_valid,
  input logic             i_wb_ack,
  input logic [`XLEN-1:0] i_wb_pc,
  input logic [31:0]      i_wb_inst,
  input logic [4:0]       i_wb_rd,
  input logic             i_wb_rd_wen,
  input logic [`XLEN-1:0] i_wb_rd_wdata,
  input logic             i_wb_skipcmt,
  input logic             i_dc_req,
  input logic             i_dc_ack
);

  // write-back held with stable fields until acknowledged
  wb_hold: assert property (@(posedge clk) disable iff (rst)
    (i_wb_valid && !i_wb_ack) |=> (i_wb_valid && $stable({i_wb_pc, i_wb_inst, i_wb_rd,
      i_wb_rd_wen, i_wb_rd_wdata, i_wb_skipcmt})))
    else $error("write-back dropped or changed before ack");

  // request still up when the ack arrives after the RAM latency
  dc_ack_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(i_dc_req) |-> ##(`RAM_LATENCY) (i_dc_req && i_dc_ack))
    else $error("data-cache request not held until an ack after the RAM latency");

  // one instruction in flight
  ready_low: assert property (@(posedge clk) disable iff (rst)
    i_wb_valid |-> !i_ex_ready)
    else $error("ready high while write-back pending");

endmodule

bind mem_stage mem_subsys_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .i_ex_ready    (o_ex_ready),
  .i_wb_valid    (o_wb_valid),
  .i_wb_ack      (i_wb_ack),
  .i_wb_pc       (o_wb_pc),
  .i_wb_inst     (o_wb_inst),
  .i_wb_rd       (o_wb_rd),
  .i_wb_rd_wen   (o_wb_rd_wen),
  .i_wb_rd_wdata (o_wb_rd_wdata),
  .i_wb_skipcmt  (o_wb_skipcmt),
  .i_dc_req      (o_dc_req),
  .i_dc_ack      (i_dc_ack)
);

// ==== rtl/mem_subsys_top.sv ====
// memory stage with its data RAM; latency depends on the channel, o_wb_valid marks the end
`timescale 1ns/1ps
`include "rv_mem_defs.svh"

module mem_subsys_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_ex_valid,
  output logic                o_ex_ready,
  input  logic [`XLEN-1:0]    i_ex_pc,
  input  logic [31:0]         i_ex_inst,
  input  logic [4:0]          i_ex_rd,
  input  logic                i_ex_rd_wen,
  input  logic [`XLEN-1:0]    i_ex_rd_wdata,
  input  rv_isa_pkg::mem_op_e i_ex_op,
  input  logic [`XLEN-1:0]    i_ex_base,
  input  logic [`XLEN-1:0]    i_ex_offset,
  input  logic [`XLEN-1:0]    i_ex_sdata,
  output logic                o_wb_valid,
  input  logic                i_wb_ack,
  output logic [`XLEN-1:0]    o_wb_pc,
  output logic [31:0]         o_wb_inst,
  output logic [4:0]          o_wb_rd,
  output logic                o_wb_rd_wen,
  output logic [`XLEN-1:0]    o_wb_rd_wdata,
  output logic                o_wb_skipcmt,
  output logic                o_clint_irq
);

  logic              dc_req;
  logic [`XLEN-1:0]  dc_addr;
  logic              dc_wen;
  rv_isa_pkg::size_e dc_size;
  logic [`XLEN-1:0]  dc_wdata;
  logic              dc_ack;
  logic [`XLEN-1:0]  dc_rdata;

  mem_stage u_mem_stage (
    .clk           (clk),
    .rst           (rst),
    .i_ex_valid    (i_ex_valid),
    .o_ex_ready    (o_ex_ready),
    .i_ex_pc       (i_ex_pc),
    .i_ex_inst     (i_ex_inst),
    .i_ex_rd       (i_ex_rd),
    .i_ex_rd_wen   (i_ex_rd_wen),
    .i_ex_rd_wdata (i_ex_rd_wdata),
    .i_ex_op       (i_ex_op),
    .i_ex_base     (i_ex_base),
    .i_ex_offset   (i_ex_offset),
    .i_ex_sdata    (i_ex_sdata),
    .o_wb_valid    (o_wb_valid),
    .i_wb_ack      (i_wb_ack),
    .o_wb_pc       (o_wb_pc),
    .o_wb_inst     (o_wb_inst),
    .o_wb_rd       (o_wb_rd),
    .o_wb_rd_wen   (o_wb_rd_wen),
    .o_wb_rd_wdata (o_wb_rd_wdata),
    .o_wb_skipcmt  (o_wb_skipcmt),
    .o_dc_req      (dc_req),
    .o_dc_addr     (dc_addr),
    .o_dc_wen      (dc_wen),
    .o_dc_size     (dc_size),
    .o_dc_wdata    (dc_wdata),
    .i_dc_ack      (dc_ack),
    .i_dc_rdata    (dc_rdata),
    .o_clint_irq   (o_clint_irq)
  );

  dcache_ram u_dcache_ram (
    .clk        (clk),
    .rst        (rst),
    .i_dc_req   (dc_req),
    .i_dc_addr  (dc_addr),
    .i_dc_wen   (dc_wen),
    .i_dc_size  (dc_size),
    .i_dc_wdata (dc_wdata),
    .o_dc_ack   (dc_ack),
    .o_dc_rdata (dc_rdata)
  );

endmodule

// ==== rtl/dcache_ram.sv ====
// data RAM standing in for the cache; aligned accesses only, addresses wrap in the RAM
// ack comes RAM_LATENCY cycles after the first request cycle
`timescale 1ns/1ps
`include "rv_mem_defs.svh"

module dcache_ram (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_dc_req,
  input  logic [`XLEN-1:0]  i_dc_addr,
  input  logic              i_dc_wen,
  input  rv_isa_pkg::size_e i_dc_size,
  input  logic [`XLEN-1:0]  i_dc_wdata,
  output logic              o_dc_ack,
  output logic [`XLEN-1:0]  o_dc_rdata
);

  localparam int IDX_W = $clog2(`RAM_WORDS);
  localparam int CNT_W = $clog2(`RAM_LATENCY + 1);

  rv_mem_pkg::lanes_u mem [`RAM_WORDS];
  rv_mem_pkg::lanes_u rd_word;
  rv_mem_pkg::lanes_u wr_word;
  logic [CNT_W-1:0]   cnt;
  logic [IDX_W-1:0]   idx;
  logic [2:0]         off;
  logic [7:0]         be;
  logic               fire;

  assign idx = i_dc_addr[IDX_W+2:3];
  assign off = i_dc_addr[2:0];
  assign rd_word = mem[idx];
  assign wr_word.raw = i_dc_wdata << {off, 3'b000};
  assign fire = i_dc_req & ~o_dc_ack & (cnt == CNT_W'(`RAM_LATENCY - 1));

  always_comb begin
    case (i_dc_size)
      rv_isa_pkg::SZ_B: be = 8'h01 << off;
      rv_isa_pkg::SZ_H: be = 8'h03 << off;
      rv_isa_pkg::SZ_W: be = 8'h0F << off;
      default: be = 8'hFF;
    endcase
  end

  // latency counter, idle while ack is out
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      o_dc_ack <= 1'b0;
    end else begin
      o_dc_ack <= fire;
      if (fire) begin
        cnt <= '0;
      end else if (i_dc_req & ~o_dc_ack) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (i_dc_wen) begin
        for (int i = 0; i < 8; i++) begin
          if (be[i]) mem[idx].b[i] <= wr_word.b[i];
        end
      end
      // addressed lane moved down to bit 0
      case (i_dc_size)
        rv_isa_pkg::SZ_B: o_dc_rdata <= {56'd0, rd_word.b[off]};
        rv_isa_pkg::SZ_H: o_dc_rdata <= {48'd0, rd_word.h[off[2:1]]};
        rv_isa_pkg::SZ_W: o_dc_rdata <= {32'd0, rd_word.w[off[2]]};
        default: o_dc_rdata <= rd_word.raw;
      endcase
    end
  end

endmodule

// ==== mem_stage/mem_stage.sv ====
// memory stage with one instruction in flight; accesses must be naturally aligned
// addresses outside both windows are passed through as no access
`timescale 1ns/1ps
`include "rv_mem_defs.svh"

module mem_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_ex_valid,
  output logic                o_ex_ready,
  input  logic [`XLEN-1:0]    i_ex_pc,
  input  logic [31:0]         i_ex_inst,
  input  logic [4:0]          i_ex_rd,
  input  logic                i_ex_rd_wen,
  input  logic [`XLEN-1:0]    i_ex_rd_wdata,
  input  rv_isa_pkg::mem_op_e i_ex_op,
  input  logic [`XLEN-1:0]    i_ex_base,
  input  logic [`XLEN-1:0]    i_ex_offset,
  input  logic [`XLEN-1:0]    i_ex_sdata,
  output logic                o_wb_valid,
  input  logic                i_wb_ack,
  output logic [`XLEN-1:0]    o_wb_pc,
  output logic [31:0]         o_wb_inst,
  output logic [4:0]          o_wb_rd,
  output logic                o_wb_rd_wen,
  output logic [`XLEN-1:0]    o_wb_rd_wdata,
  output logic                o_wb_skipcmt,
  output logic                o_dc_req,
  output logic [`XLEN-1:0]    o_dc_addr,
  output logic                o_dc_wen,
  output rv_isa_pkg::size_e   o_dc_size,
  output logic [`XLEN-1:0]    o_dc_wdata,
  input  logic                i_dc_ack,
  input  logic [`XLEN-1:0]    i_dc_rdata,
  output logic                o_clint_irq
);

  logic                busy;
  logic                accept;
  logic                wb_hs;
  logic                start_q;
  logic                mmio_done_q;
  logic                dc_start;
  logic                dc_done;
  logic                clint_access;
  logic                slave_done;
  logic [`XLEN-1:0]    ea;
  logic                dec_rd;
  logic                dec_wr;
  rv_isa_pkg::size_e   dec_size;
  logic [`XLEN-1:0]    dec_wdata;
  rv_mem_pkg::chan_e   dec_chan;
  rv_mem_pkg::chan_e   chan_q;
  rv_isa_pkg::mem_op_e op_q;
  rv_isa_pkg::size_e   size_q;
  logic                wen_q;
  logic [`XLEN-1:0]    addr_q;
  logic [`XLEN-1:0]    wdata_q;
  logic [`XLEN-1:0]    fwd_q;
  logic [`XLEN-1:0]    dc_rdata;
  logic [`XLEN-1:0]    clint_rdata;
  rv_mem_pkg::lanes_u  ld;

  assign o_ex_ready = ~busy;
  assign accept = i_ex_valid & ~busy;
  assign wb_hs = o_wb_valid & i_wb_ack;

  // decode on the execute fields
  assign ea = i_ex_base + i_ex_offset;
  assign dec_rd = i_ex_op inside {rv_isa_pkg::LB, rv_isa_pkg::LBU, rv_isa_pkg::LH,
                                  rv_isa_pkg::LHU, rv_isa_pkg::LW, rv_isa_pkg::LWU,
                                  rv_isa_pkg::LD};
  assign dec_wr = i_ex_op inside {rv_isa_pkg::SB, rv_isa_pkg::SH, rv_isa_pkg::SW,
                                  rv_isa_pkg::SD};

  always_comb begin
    case (i_ex_op)
      rv_isa_pkg::LB, rv_isa_pkg::LBU, rv_isa_pkg::SB: dec_size = rv_isa_pkg::SZ_B;
      rv_isa_pkg::LH, rv_isa_pkg::LHU, rv_isa_pkg::SH: dec_size = rv_isa_pkg::SZ_H;
      rv_isa_pkg::LW, rv_isa_pkg::LWU, rv_isa_pkg::SW: dec_size = rv_isa_pkg::SZ_W;
      default: dec_size = rv_isa_pkg::SZ_D;
    endcase
  end

  // store data right-aligned, upper lanes cleared
  always_comb begin
    case (dec_size)
      rv_isa_pkg::SZ_B: dec_wdata = {56'd0, i_ex_sdata[7:0]};
      rv_isa_pkg::SZ_H: dec_wdata = {48'd0, i_ex_sdata[15:0]};
      rv_isa_pkg::SZ_W: dec_wdata = {32'd0, i_ex_sdata[31:0]};
      default: dec_wdata = i_ex_sdata;
    endcase
  end

  always_comb begin
    if (!(dec_rd | dec_wr)) begin
      dec_chan = rv_mem_pkg::NONE;
    end else if ((ea[31:0] & `WIN_MASK) == `MEM_BASE) begin
      dec_chan = rv_mem_pkg::MEM;
    end else if ((ea[31:0] & `WIN_MASK) == `MMIO_BASE) begin
      dec_chan = rv_mem_pkg::MMIO;
    end else begin
      dec_chan = rv_mem_pkg::NONE;
    end
  end

  // start exactly one slave the cycle after accept
  assign dc_start = start_q & (chan_q == rv_mem_pkg::MEM);
  assign clint_access = start_q & (chan_q == rv_mem_pkg::MMIO);
  assign slave_done = dc_done | mmio_done_q | (start_q & (chan_q == rv_mem_pkg::NONE));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      start_q <= 1'b0;
      mmio_done_q <= 1'b0;
      o_wb_valid <= 1'b0;
      chan_q <= rv_mem_pkg::NONE;
    end else begin
      start_q <= accept;
      mmio_done_q <= clint_access;
      if (accept) begin
        busy <= 1'b1;
        chan_q <= dec_chan;
      end else if (wb_hs) begin
        busy <= 1'b0;
      end
      if (slave_done) begin
        o_wb_valid <= 1'b1;
      end else if (wb_hs) begin
        o_wb_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_wb_pc <= i_ex_pc;
      o_wb_inst <= i_ex_inst;
      o_wb_rd <= i_ex_rd;
      o_wb_rd_wen <= i_ex_rd_wen;
      fwd_q <= i_ex_rd_wdata;
      op_q <= i_ex_op;
      size_q <= dec_size;
      wen_q <= dec_wr;
      addr_q <= ea;
      wdata_q <= dec_wdata;
    end
  end

  // slave data is held until the next access, so this stays stable during write-back
  assign ld.raw = (chan_q == rv_mem_pkg::MMIO) ? clint_rdata : dc_rdata;

  always_comb begin
    if (chan_q == rv_mem_pkg::NONE) begin
      o_wb_rd_wdata = fwd_q;
    end else begin
      case (op_q)
        rv_isa_pkg::LB:  o_wb_rd_wdata = {{56{ld.b[0][7]}}, ld.b[0]};
        rv_isa_pkg::LBU: o_wb_rd_wdata = {56'd0, ld.b[0]};
        rv_isa_pkg::LH:  o_wb_rd_wdata = {{48{ld.h[0][15]}}, ld.h[0]};
        rv_isa_pkg::LHU: o_wb_rd_wdata = {48'd0, ld.h[0]};
        rv_isa_pkg::LW:  o_wb_rd_wdata = {{32{ld.w[0][31]}}, ld.w[0]};
        rv_isa_pkg::LWU: o_wb_rd_wdata = {32'd0, ld.w[0]};
        rv_isa_pkg::LD:  o_wb_rd_wdata = ld.raw;
        default: o_wb_rd_wdata = fwd_q;
      endcase
    end
  end

  assign o_wb_skipcmt = (chan_q == rv_mem_pkg::MMIO);

  mem_dcache_port u_dcache_port (
    .clk        (clk),
    .rst        (rst),
    .i_start    (dc_start),
    .i_addr     (addr_q),
    .i_wen      (wen_q),
    .i_size     (size_q),
    .i_wdata    (wdata_q),
    .o_done     (dc_done),
    .o_rdata    (dc_rdata),
    .o_dc_req   (o_dc_req),
    .o_dc_addr  (o_dc_addr),
    .o_dc_wen   (o_dc_wen),
    .o_dc_size  (o_dc_size),
    .o_dc_wdata (o_dc_wdata),
    .i_dc_ack   (i_dc_ack),
    .i_dc_rdata (i_dc_rdata)
  );

  mem_clint u_clint (
    .clk         (clk),
    .rst         (rst),
    .i_access    (clint_access),
    .i_addr      (addr_q[31:0]),
    .i_wen       (wen_q),
    .i_wdata     (wdata_q),
    .o_rdata     (clint_rdata),
    .o_clint_irq (o_clint_irq)
  );

endmodule

// ==== mem_stage/mem_clint.sv ====
// CLINT with mtime and mtimecmp only; accesses are taken as full 64-bit words
`timescale 1ns/1ps
`include "rv_mem_defs.svh"

module mem_clint (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_access,
  input  logic [31:0]      i_addr,
  input  logic             i_wen,
  input  logic [`XLEN-1:0] i_wdata,
  output logic [`XLEN-1:0] o_rdata,
  output logic             o_clint_irq
);

  logic [`XLEN-1:0] mtime;
  logic [`XLEN-1:0] mtimecmp;
  logic             wr_mtime;
  logic             wr_mtimecmp;

  assign wr_mtime = i_access & i_wen & (i_addr == `CLINT_MTIME);
  assign wr_mtimecmp = i_access & i_wen & (i_addr == `CLINT_MTIMECMP);

  // free-running timer unless software loads it
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else if (wr_mtime) begin
      mtime <= i_wdata;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  // all ones keeps the irq low after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp <= '1;
    end else if (wr_mtimecmp) begin
      mtimecmp <= i_wdata;
    end
  end

  // read data valid the cycle after the access
  always_ff @(posedge clk) begin
    if (i_access) begin
      case (i_addr)
        `CLINT_MTIME: o_rdata <= mtime;
        `CLINT_MTIMECMP: o_rdata <= mtimecmp;
        default: o_rdata <= '0;
      endcase
    end
  end

  assign o_clint_irq = (mtime >= mtimecmp);

endmodule

// ==== mem_stage/mem_dcache_port.sv ====
// one outstanding data-cache request; i_start must not repeat before o_done
`timescale 1ns/1ps
`include "rv_mem_defs.svh"

module mem_dcache_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_start,
  input  logic [`XLEN-1:0]  i_addr,
  input  logic              i_wen,
  input  rv_isa_pkg::size_e i_size,
  input  logic [`XLEN-1:0]  i_wdata,
  output logic              o_done,
  output logic [`XLEN-1:0]  o_rdata,
  output logic              o_dc_req,
  output logic [`XLEN-1:0]  o_dc_addr,
  output logic              o_dc_wen,
  output rv_isa_pkg::size_e o_dc_size,
  output logic [`XLEN-1:0]  o_dc_wdata,
  input  logic              i_dc_ack,
  input  logic [`XLEN-1:0]  i_dc_rdata
);

  // done in the ack cycle so write-back follows one cycle later
  assign o_done = o_dc_req & i_dc_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_dc_req <= 1'b0;
    end else if (i_start) begin
      o_dc_req <= 1'b1;
    end else if (i_dc_ack) begin
      o_dc_req <= 1'b0;
    end
  end

  // request fields held for the whole handshake
  always_ff @(posedge clk) begin
    if (i_start) begin
      o_dc_addr <= i_addr;
      o_dc_wen <= i_wen;
      o_dc_size <= i_size;
      o_dc_wdata <= i_wdata;
    end
  end

  // response kept until the next request completes
  always_ff @(posedge clk) begin
    if (o_done) begin
      o_rdata <= i_dc_rdata;
    end
  end

endmodule

// ==== common/rv_mem_pkg.sv ====
// data-side types of the memory stage
// lanes_u assumes XLEN of 64
`include "rv_mem_defs.svh"

package rv_mem_pkg;

  // slave that serves the access
  typedef enum logic [1:0] {
    NONE = 2'd0,
    MEM  = 2'd1,
    MMIO = 2'd2
  } chan_e;

  // one data word seen as raw bits or as lanes
  typedef union packed {
    logic [`XLEN-1:0] raw;
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
  } lanes_u;

endpackage

// ==== common/rv_isa_pkg.sv ====
// instruction-side types of the memory stage
package rv_isa_pkg;

  // memory opcodes as decoded by execute
  typedef enum logic [7:0] {
    NONE = 8'h00,
    LB   = 8'h01,
    LBU  = 8'h02,
    LH   = 8'h03,
    LHU  = 8'h04,
    LW   = 8'h05,
    LWU  = 8'h06,
    LD   = 8'h07,
    SB   = 8'h08,
    SH   = 8'h09,
    SW   = 8'h0A,
    SD   = 8'h0B
  } mem_op_e;

  // log2 of the access size in bytes
  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2,
    SZ_D = 2'd3
  } size_e;

endpackage

// ==== common/rv_mem_defs.svh ====
// widths and address map shared by the memory stage, its slaves and the RAM
// both windows are decoded on the low 32 address bits only
`ifndef RV_MEM_DEFS_SVH
`define RV_MEM_DEFS_SVH

// data path
`define XLEN 64
`define RAM_WORDS 256

// address windows, 16 MiB each
`define MEM_BASE 32'h8000_0000
`define MMIO_BASE 32'h0200_0000
`define WIN_MASK 32'hFF00_0000

// clint registers
`define CLINT_MTIMECMP 32'h0200_4000
`define CLINT_MTIME 32'h0200_BFF8

// cycles from first request cycle to ack
`define RAM_LATENCY 2

`endif
